//--- source/zports_pkg.sv
`default_nettype none

package zports_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus and register types

	typedef logic [7:0]  byte_t;    // z80 data byte
	typedef logic [15:0] io_addr_t; // full i/o address
	typedef logic [5:0]  border_t;  // 2 bits per rgb component
	typedef logic [5:0]  page_t;    // pentagon-1m ram page

	// port xt unlock sequence of aa, index and data
	typedef enum logic [1:0] {
		xt_idle = 2'd0,
		xt_addr = 2'd1,
		xt_data = 2'd2
	} xt_state_e;

	//////////////////////////////////////////////////////////////////////
	// port low bytes

	localparam byte_t PORT_FE = 8'hFE; // keys, tape, border, beeper
	localparam byte_t PORT_FD = 8'hFD; // 7ffd paging and ay
	localparam byte_t PORT_F7 = 8'hF7; // eff7 paging

	// soundrive channels shadowed by dos
	localparam byte_t PORT_SD0 = 8'h0F;
	localparam byte_t PORT_SD1 = 8'h1F;
	localparam byte_t PORT_SD2 = 8'h4F;
	localparam byte_t PORT_SD3 = 8'h5F;

	// covox hits all four channels
	localparam byte_t PORT_CVX1 = 8'hFB;
	localparam byte_t PORT_CVX2 = 8'hDD;

	localparam byte_t PORT_KJOY   = 8'h1F; // kempston joystick
	localparam byte_t PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam byte_t PORT_XT_RD  = 8'hEF; // xt register readback

	//////////////////////////////////////////////////////////////////////
	// port xt

	localparam io_addr_t PORT_XT_FULL = 16'h55FF;
	localparam byte_t    XT_UNLOCK    = 8'hAA;

	localparam byte_t XT_REG_BORDER = 8'h00; // extended border
	localparam byte_t XT_REG_VCFG   = 8'h08; // video config

	// unmapped reads float high
	localparam byte_t BYTE_IDLE = 8'hFF;

endpackage

`default_nettype wire

//--- source/port_decode.sv
`default_nettype none

module port_decode
	import zports_pkg::*;
(
	input  wire           zclk,
	input  wire           rst_n,
	input  wire io_addr_t a,
	input  wire           iorq_n,
	input  wire           rd_n,
	input  wire           wr_n,
	input  wire           dos,
	output logic          porthit,
	output logic          dataout,
	output logic          ay_bc1,
	output logic          ay_bdir,
	output logic          fe_wr,
	output logic          p7ffd_wr,
	output logic          peff7_wr,
	output logic [3:0]    dac_wr,
	output logic          xt_wr,
	output logic          other_wr
);

	byte_t loa;
	logic  iowr_now;
	logic  iord_now;
	logic  iowr_q;
	logic  iord_q;
	logic  port_wr;
	logic  port_rd;
	logic  ay_fffd;
	logic  ay_bffd;
	logic  cvx_hit;
	logic  xt_hit;

	assign loa      = a[7:0];
	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	// one-cycle pulses on the leading edge of the strobes
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q  <= 1'b0;
			iord_q  <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			iowr_q  <= iowr_now;
			iord_q  <= iord_now;
			port_wr <= iowr_now & ~iowr_q;
			port_rd <= iord_now & ~iord_q;
		end
	end

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_FD, PORT_KMOUSE, PORT_XT_RD, PORT_CVX1, PORT_CVX2:
				porthit = 1'b1;
			PORT_SD0, PORT_SD1, PORT_SD2, PORT_SD3, PORT_F7:
				porthit = ~dos; // hidden while shadow is on
			default:
				porthit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// ay chip select for fffd register and bffd data

	assign ay_fffd = (loa == PORT_FD) && (a[15:14] == 2'b11);
	assign ay_bffd = (loa == PORT_FD) && (a[15:14] == 2'b10);
	assign ay_bc1  = ay_fffd & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = (ay_fffd | ay_bffd) & iowr_now;

	// ay drives the bus itself on fffd reads
	assign dataout = porthit & iord_now & ~ay_fffd;

	//////////////////////////////////////////////////////////////////////
	// per-function write pulses

	assign cvx_hit = (loa == PORT_CVX1) || (loa == PORT_CVX2);
	assign xt_hit  = (a == PORT_XT_FULL);

	assign fe_wr    = port_wr && (loa == PORT_FE);
	assign p7ffd_wr = port_wr && (loa == PORT_FD) && !a[15];
	assign peff7_wr = port_wr && (loa == PORT_F7) && !a[12] && !dos;
	assign xt_wr    = port_wr && xt_hit;
	assign other_wr = port_wr && !xt_hit; // breaks the xt sequence

	assign dac_wr[0] = port_wr && (cvx_hit || ((loa == PORT_SD0) && !dos));
	assign dac_wr[1] = port_wr && (cvx_hit || ((loa == PORT_SD1) && !dos));
	assign dac_wr[2] = port_wr && (cvx_hit || ((loa == PORT_SD2) && !dos));
	assign dac_wr[3] = port_wr && (cvx_hit || ((loa == PORT_SD3) && !dos));

	a_wr_rd_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

`default_nettype wire

//--- source/mem_paging.sv
`default_nettype none

module mem_paging
	import zports_pkg::*;
(
	input  wire        zclk,
	input  wire        rst_n,
	input  wire byte_t din,
	input  wire        p7ffd_wr,
	input  wire        peff7_wr,
	input  wire [1:0]  rstrom,
	output byte_t      p7ffd,
	output byte_t      peff7,
	output page_t      pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	byte_t p7ffd_reg; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 high page
	byte_t peff7_reg; // 2 block1m, 3 ram0
	logic  rom_bit;
	logic  rstsync1;
	logic  rstsync2;
	logic  block1m;
	logic  block7ffd;

	assign block1m   = peff7_reg[2];
	assign block7ffd = p7ffd_reg[5] & block1m;

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_reg <= '0;
		else if (p7ffd_wr && !block7ffd)
			p7ffd_reg <= din;
	end

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			peff7_reg <= '0;
		else if (peff7_wr)
			peff7_reg <= din;
	end

	//////////////////////////////////////////////////////////////////////
	// rom choice reloaded as reset goes away

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			rstsync1 <= 1'b1;
			rstsync2 <= 1'b1;
		end
		else
		begin
			rstsync1 <= 1'b0;
			rstsync2 <= rstsync1;
		end
	end

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			rom_bit <= 1'b0;
		else if (rstsync2 && !rstsync1) // one cycle after release
			rom_bit <= rstrom[0];
		else if (p7ffd_wr && !block7ffd)
			rom_bit <= din[4];
	end

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_reg[7:5]), rom_bit, p7ffd_reg[3:0]};
	assign peff7 = block1m ?
		{peff7_reg[7], 1'b0, peff7_reg[5:4], 3'b000, peff7_reg[0]} : peff7_reg;

	assign pent1m_page   = {p7ffd_reg[7:5], p7ffd_reg[2:0]};
	assign pent1m_rom    = p7ffd_reg[4];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_reg[3];

	a_lock_holds: assert property (@(posedge zclk) disable iff (!rst_n)
		p7ffd_wr && block7ffd |=> $stable(p7ffd_reg));

endmodule

`default_nettype wire

//--- source/sound_dac.sv
`default_nettype none

module sound_dac
	import zports_pkg::*;
(
	input  wire        zclk,
	input  wire        rst_n,
	input  wire byte_t din,
	input  wire        fe_wr,
	input  wire [3:0]  dac_wr,
	output byte_t      psd0,
	output byte_t      psd1,
	output byte_t      psd2,
	output byte_t      psd3
);

	byte_t chan [4];

	//////////////////////////////////////////////////////////////////////
	// channel registers

	// soundrive/covox writes take the whole byte and fe fills it from one bit
	for (genvar i = 0; i < 4; i++)
	begin : g_chan
		always_ff @(posedge zclk, negedge rst_n)
		begin
			if (!rst_n)
				chan[i] <= '0;
			else if (dac_wr[i])
				chan[i] <= din;
			else if (fe_wr)
			begin
				if (i < 2)
					chan[i] <= {8{din[4]}}; // beeper
				else
					chan[i] <= {8{din[3]}}; // tape out
			end
		end
	end

	assign psd0 = chan[0];
	assign psd1 = chan[1];
	assign psd2 = chan[2];
	assign psd3 = chan[3];

endmodule

`default_nettype wire

//--- source/xt_config.sv
`default_nettype none

module xt_config
	import zports_pkg::*;
(
	input  wire        zclk,
	input  wire        rst_n,
	input  wire byte_t din,
	input  wire        fe_wr,
	input  wire        xt_wr,
	input  wire        other_wr,
	output border_t    border,
	output byte_t      vcfg,
	output byte_t      xt_rd_data
);

	xt_state_e xt_state;
	byte_t     xt_idx; // latched register index
	logic      xt_reg_wr;

	//////////////////////////////////////////////////////////////////////
	// unlock sequence on 55ff

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			xt_state <= xt_idle;
			xt_idx   <= '0;
		end
		else if (other_wr)
			xt_state <= xt_idle; // any foreign write aborts
		else if (xt_wr)
		begin
			case (xt_state)
				xt_idle:
					if (din == XT_UNLOCK)
						xt_state <= xt_addr;
				xt_addr:
				begin
					xt_idx   <= din;
					xt_state <= xt_data;
				end
				default:
					xt_state <= xt_idle; // data byte done
			endcase
		end
	end

	assign xt_reg_wr = xt_wr && (xt_state == xt_data);

	//////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			border <= '0;
		else if (xt_reg_wr && (xt_idx == XT_REG_BORDER))
			border <= din[5:0];
		else if (fe_wr)
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0}; // spectrum grb to rrggbb
	end

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			vcfg <= '0;
		else if (xt_reg_wr && (xt_idx == XT_REG_VCFG))
			vcfg <= din;
	end

	// only the border reads back
	assign xt_rd_data = (xt_idx == XT_REG_BORDER) ? {2'b00, border} : BYTE_IDLE;

	a_xt_state_legal: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_state inside {xt_idle, xt_addr, xt_data});

endmodule

`default_nettype wire

//--- source/read_mux.sv
`default_nettype none

module read_mux
	import zports_pkg::*;
(
	input  wire io_addr_t a,
	input  wire           dos,
	input  wire [4:0]     keys_in,
	input  wire           tape_read,
	input  wire [4:0]     kj_in,
	input  wire byte_t    mus_in,
	input  wire byte_t    xt_rd_data,
	output byte_t         dout
);

	always_comb
	begin
		case (a[7:0])
			PORT_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_KJOY:
				dout = dos ? BYTE_IDLE : {3'b000, kj_in}; // 1f belongs to fdc in dos
			PORT_KMOUSE:
				dout = mus_in;
			PORT_XT_RD:
				dout = xt_rd_data;
			default:
				dout = BYTE_IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- source/zports.sv
`default_nettype none

module zports
	import zports_pkg::*;
(
	input  wire           zclk,
	input  wire           rst_n,
	// z80 bus
	input  wire io_addr_t a,
	input  wire byte_t    din,
	input  wire           iorq_n,
	input  wire           rd_n,
	input  wire           wr_n,
	// mode
	input  wire           dos,
	input  wire [1:0]     rstrom,
	// read sources
	input  wire [4:0]     keys_in,
	input  wire           tape_read,
	input  wire [4:0]     kj_in,
	input  wire byte_t    mus_in,
	output wire           porthit,
	output wire           dataout,
	output wire byte_t    dout,
	output wire           ay_bc1,
	output wire           ay_bdir,
	output wire border_t  border,
	output wire byte_t    vcfg,
	output wire byte_t    psd0,
	output wire byte_t    psd1,
	output wire byte_t    psd2,
	output wire byte_t    psd3,
	output wire byte_t    p7ffd,
	output wire byte_t    peff7,
	output wire page_t    pent1m_page,
	output wire           pent1m_rom,
	output wire           pent1m_1m_on,
	output wire           pent1m_ram0_0
);

	logic       fe_wr;
	logic       p7ffd_wr;
	logic       peff7_wr;
	logic [3:0] dac_wr;
	logic       xt_wr;
	logic       other_wr;
	byte_t      xt_rd_data;

	port_decode port_decode_inst (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.a        (a),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.dos      (dos),
		.porthit  (porthit),
		.dataout  (dataout),
		.ay_bc1   (ay_bc1),
		.ay_bdir  (ay_bdir),
		.fe_wr    (fe_wr),
		.p7ffd_wr (p7ffd_wr),
		.peff7_wr (peff7_wr),
		.dac_wr   (dac_wr),
		.xt_wr    (xt_wr),
		.other_wr (other_wr)
	);

	mem_paging mem_paging_inst (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.din           (din),
		.p7ffd_wr      (p7ffd_wr),
		.peff7_wr      (peff7_wr),
		.rstrom        (rstrom),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	sound_dac sound_dac_inst (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.din    (din),
		.fe_wr  (fe_wr),
		.dac_wr (dac_wr),
		.psd0   (psd0),
		.psd1   (psd1),
		.psd2   (psd2),
		.psd3   (psd3)
	);

	xt_config xt_config_inst (
		.zclk       (zclk),
		.rst_n      (rst_n),
		.din        (din),
		.fe_wr      (fe_wr),
		.xt_wr      (xt_wr),
		.other_wr   (other_wr),
		.border     (border),
		.vcfg       (vcfg),
		.xt_rd_data (xt_rd_data)
	);

	read_mux read_mux_inst (
		.a          (a),
		.dos        (dos),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.kj_in      (kj_in),
		.mus_in     (mus_in),
		.xt_rd_data (xt_rd_data),
		.dout       (dout)
	);

endmodule

`default_nettype wire

//--- sim/zports_tb.sv
`default_nettype none

module zports_tb
	import zports_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_LINES = 400;  // stimulus file length bound
	localparam int ROM_WAIT  = 8;    // cycles allowed for the rom reload

	logic     zclk = 1'b0;
	logic     rst_n;
	io_addr_t a;
	byte_t    din;
	logic     iorq_n;
	logic     rd_n;
	logic     wr_n;
	logic     dos;
	logic [1:0] rstrom;
	logic [4:0] keys_in;
	logic     tape_read;
	logic [4:0] kj_in;
	byte_t    mus_in;
	logic     porthit;
	logic     dataout;
	byte_t    dout;
	logic     ay_bc1;
	logic     ay_bdir;
	border_t  border;
	byte_t    vcfg;
	byte_t    psd0;
	byte_t    psd1;
	byte_t    psd2;
	byte_t    psd3;
	byte_t    p7ffd;
	byte_t    peff7;
	page_t    pent1m_page;
	logic     pent1m_rom;
	logic     pent1m_1m_on;
	logic     pent1m_ram0_0;

	int          fd;
	int          nf;
	int          n;
	int          checks;
	int          dos_v;
	int          rom_v;
	string       line;
	logic [63:0] op_s;
	logic [63:0] grp_s;
	logic [15:0] addr_v;
	logic [7:0]  data_v;
	logic [31:0] exp_v;

	zports zports_inst (.*);

	always #4 zclk = ~zclk; // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// checking

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// outputs that follow the bus within the cycle
	function automatic logic in_cycle_group(input logic [63:0] grp);
		return (grp == "bus") || (grp == "dout") || (grp == "keys") ||
			(grp == "joy") || (grp == "mouse");
	endfunction

	task automatic check_group(input logic [63:0] grp, input logic [31:0] exp);
		case (grp)
			"none":
				checks = checks; // cycle only moves state
			"bus":
				check_value("{porthit,dataout,ay_bc1,ay_bdir}",
					{porthit, dataout, ay_bc1, ay_bdir}, exp);
			"dout":
				check_value("dout", dout, exp);
			"keys":
				check_value("dout", dout, {24'd0, 1'b1, tape_read, 1'b0, keys_in});
			"joy":
				check_value("dout", dout, {24'd0, 3'b000, kj_in});
			"mouse":
				check_value("dout", dout, {24'd0, mus_in});
			"border":
				check_value("border", border, exp);
			"vcfg":
				check_value("vcfg", vcfg, exp);
			"psd":
				check_value("{psd3,psd2,psd1,psd0}", {psd3, psd2, psd1, psd0}, exp);
			"p7ffd":
				check_value("p7ffd", p7ffd, exp);
			"peff7":
				check_value("peff7", peff7, exp);
			"page":
				check_value("{pent1m_1m_on,pent1m_ram0_0,pent1m_rom,pent1m_page}",
					{pent1m_1m_on, pent1m_ram0_0, pent1m_rom, pent1m_page}, exp);
			default:
			begin
				$display("stimulus file names an unknown output group");
				stop_with_failure();
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus driver

	// rom bit of 7ffd is reloaded a couple of edges after reset release
	task automatic wait_rom_reload();
		int cnt;
		cnt = 0;
		while (p7ffd[4] !== rstrom[0])
		begin
			if (cnt == ROM_WAIT)
			begin
				$display("timeout waiting for the rom bit to reload after reset");
				stop_with_failure();
			end
			else
			begin
				cnt++;
				@(negedge zclk);
			end
		end
	endtask

	task automatic io_cycle(input logic is_wr, input io_addr_t adr, input byte_t dat,
		input logic mode_dos, input logic [1:0] mode_rom, input logic [63:0] grp,
		input logic [31:0] exp);
		logic        during;
		logic [31:0] rnd;
		int          gap;
		during = in_cycle_group(grp);
		rnd    = $urandom;
		gap    = 1 + ($urandom % 3);
		@(posedge zclk);
		a      <= adr;
		din    <= dat;
		dos    <= mode_dos;
		rstrom <= mode_rom;
		iorq_n <= 1'b0;
		rd_n   <= is_wr;
		wr_n   <= !is_wr;
		if (!is_wr)
		begin
			keys_in   <= rnd[4:0];
			tape_read <= rnd[5];
			kj_in     <= rnd[10:6];
			mus_in    <= rnd[18:11];
		end
		@(posedge zclk);
		@(posedge zclk);
		@(negedge zclk);
		if (during)
			check_group(grp, exp);
		@(posedge zclk);
		@(posedge zclk); // fourth edge with the strobes low
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		@(posedge zclk);
		@(negedge zclk);
		if (!during)
			check_group(grp, exp);
		repeat (gap) @(posedge zclk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		void'($urandom(32'hcb66_6838));
		checks    = 0;
		rst_n     = 1'b0;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		rstrom    = 2'b01;
		keys_in   = '0;
		tape_read = 1'b0;
		kj_in     = '0;
		mus_in    = '0;
		repeat (16) @(posedge zclk);
		rst_n <= 1'b1;
		wait_rom_reload();

		fd = $fopen("sim/zports_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file sim/zports_stimulus.txt");
			stop_with_failure();
		end
		else
		begin
			n = 0;
			while (!$feof(fd))
			begin
				if (n == MAX_LINES)
				begin
					$display("stimulus file did not end within %0d lines", MAX_LINES);
					stop_with_failure();
				end
				else
				begin
					n++;
					nf = $fgets(line, fd);
					if (nf > 0 && line.len() > 2 && line[0] != "#")
					begin
						nf = $sscanf(line, "%s %h %h %d %d %s %h", op_s, addr_v,
							data_v, dos_v, rom_v, grp_s, exp_v);
						if (nf != 7 || (op_s != "W" && op_s != "R"))
						begin
							$display("malformed stimulus line %0d", n);
							stop_with_failure();
						end
						else
							io_cycle(op_s == "W", addr_v, data_v, dos_v[0], rom_v[1:0],
								grp_s, exp_v);
					end
				end
			end
			$fclose(fd);

			if (checks == 0)
			begin
				$display("the stimulus file held no checks");
				stop_with_failure();
			end
			else
			begin
				$display("Simulation PASSED");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/zports_stimulus.txt
# op address data dos rstrom group expected   (op W or R, address, data and expected in hex)
# bus={porthit,dataout,bc1,bdir} psd={psd3..psd0} page={1m_on,ram0_0,rom,page}; keys/joy/mouse from tb
# reset values
R 0033 00 0 1 bus    0
R 0033 00 0 1 dout   FF
R 0033 00 0 1 border 00
R 0033 00 0 1 vcfg   00
R 0033 00 0 1 psd    00000000
R 0033 00 0 1 p7ffd  10
R 0033 00 0 1 peff7  00
R 0033 00 0 1 page   100
# port fe
W 00FE 15 0 1 psd    0000FFFF
R 0033 00 0 1 border 0A
W 00FE 0E 0 1 border 28
R 0033 00 0 1 psd    FFFF0000
R 00FE 00 0 1 keys   0
# soundrive and covox
W 000F 11 0 1 psd    FFFF0011
W 001F 22 0 1 psd    FFFF2211
W 004F 33 0 1 psd    FF332211
W 005F 44 0 1 psd    44332211
W 00FB 5A 0 1 psd    5A5A5A5A
W 00DD A5 0 1 psd    A5A5A5A5
W 000F 77 1 1 bus    0
W 000F 77 1 1 psd    A5A5A5A5
R 001F 00 0 1 joy    0
# paging and the 1 MB lock
W 7FFD C2 0 1 page   132
W EFF7 3D 0 1 peff7  31
R 0033 00 0 1 p7ffd  02
R 0033 00 0 1 page   0B2
W 7FFD 25 0 1 p7ffd  05
W 7FFD 07 0 1 p7ffd  05
W 7FFD 12 0 1 page   08D
W EFF7 00 1 1 peff7  31
W EFF7 00 0 1 p7ffd  25
# port xt
W 55FF AA 0 1 none   0
W 55FF 00 0 1 none   0
W 55FF 3B 0 1 border 3B
R 00EF 00 0 1 dout   3B
W 55FF AA 0 1 none   0
W 55FF 08 0 1 none   0
W 55FF 5C 0 1 vcfg   5C
R 00EF 00 0 1 dout   FF
W 55FF AA 0 1 none   0
W 00FE 00 0 1 border 00
W 55FF 00 0 1 none   0
W 55FF 77 0 1 border 00
# ay and mouse
R FFFD 00 0 1 bus    A
W FFFD 03 0 1 bus    B
W BFFD 55 0 1 bus    9
W BFFD 55 0 1 p7ffd  25
R 00DF 00 0 1 mouse  0
R 00DF 00 0 1 bus    C

//--- tb.f
source/zports_pkg.sv
source/port_decode.sv
source/mem_paging.sv
source/sound_dac.sv
source/xt_config.sv
source/read_mux.sv
source/zports.sv
sim/zports_tb.sv

//--- Bender.yml
package:
  name: zports

sources:
  - source/zports_pkg.sv
  - source/port_decode.sv
  - source/mem_paging.sv
  - source/sound_dac.sv
  - source/xt_config.sv
  - source/read_mux.sv
  - source/zports.sv
  - target: simulation
    files:
      - sim/zports_tb.sv
